// ==== dcache_ctrl.sv ====
// hit/miss decision, request ready, CDB register and halt FSM
`default_nettype none

module dcache_ctrl
  import mem_bus_pkg::*;
  import dcache_pkg::*;
#(
  parameter int IDX_BITS = 5
) (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 req_valid,
  input  logic                 req_store,
  input  logic [ADDR_BITS-1:0] req_addr,
  input  logic [WORD_BITS-1:0] req_data,
  input  logic [PR_BITS-1:0]   req_pr,
  input  logic [AR_BITS-1:0]   req_ar,
  output logic                 req_ready,
  input  logic                 halt,
  output logic                 halted,
  input  logic                 hit,
  input  logic [WORD_BITS-1:0] hit_data,
  input  logic                 queue_full,
  input  logic                 queue_empty,
  output logic                 push,
  output bus_cmd_t             push_cmd,
  output logic [ADDR_BITS-1:0] push_addr,
  output logic [WORD_BITS-1:0] push_data,
  output logic [PR_BITS-1:0]   push_pr,
  output logic [AR_BITS-1:0]   push_ar,
  input  logic                 fill_valid,
  input  logic [PR_BITS-1:0]   fill_pr,
  input  logic [AR_BITS-1:0]   fill_ar,
  input  logic [ADDR_BITS-1:0] fill_addr,
  input  logic [WORD_BITS-1:0] fill_data,
  input  logic                 fill_alloc,
  input  logic                 any_pending,
  output logic                 store_en,
  output logic                 store_strobe,
  output logic [ADDR_BITS-1:0] store_addr,
  output logic [WORD_BITS-1:0] store_data,
  output logic                 fill_en,
  output logic [ADDR_BITS-1:0] fill_wr_addr,
  output logic [WORD_BITS-1:0] fill_wr_data,
  output logic                 cdb_valid,
  output logic [PR_BITS-1:0]   cdb_pr,
  output logic [AR_BITS-1:0]   cdb_ar,
  output logic [WORD_BITS-1:0] cdb_data
);

  halt_state_t state;
  logic        accept;
  logic        load_hit;

  // returning data owns the CDB this cycle, so hold off new requests
  assign req_ready = (state == run) && !queue_full && !fill_valid;
  assign accept    = req_valid && req_ready;
  assign load_hit  = accept && !req_store && hit;

  // every store and every load miss goes out on the bus
  assign push      = accept && (req_store || !hit);
  assign push_cmd  = req_store ? bus_store : bus_load;
  assign push_addr = req_addr;
  assign push_data = req_data;
  assign push_pr   = req_pr;
  assign push_ar   = req_ar;

  // stale fills skip the cache but still broadcast
  assign fill_en      = fill_valid && fill_alloc;
  assign fill_wr_addr = fill_addr;
  assign fill_wr_data = fill_data;

  assign store_strobe = accept && req_store;
  assign store_addr   = req_addr;
  assign store_data   = req_data;
  assign store_en     = store_strobe;

  always_ff @(posedge clock)
  begin
    if (reset)
      cdb_valid <= 1'b0;
    else
      cdb_valid <= fill_valid || load_hit;
  end

  always_ff @(posedge clock)
  begin
    if (fill_valid)
    begin
      cdb_pr   <= fill_pr;
      cdb_ar   <= fill_ar;
      cdb_data <= fill_data;
    end
    else
    begin
      cdb_pr   <= req_pr;
      cdb_ar   <= req_ar;
      cdb_data <= hit_data;
    end
  end

  always_ff @(posedge clock)
  begin
    if (reset)
      state <= run;
    else
    begin
      case (state)
        run:      if (halt) state <= draining;
        draining: if (queue_empty && !any_pending) state <= dcache_pkg::halted;
        default:  state <= state;  // halted is final
      endcase
    end
  end

  assign halted = (state == dcache_pkg::halted);

endmodule

`default_nettype wire

// ==== dcache_mem.sv ====
// direct-mapped tag, valid and data arrays with lookup, store and fill ports
`default_nettype none

module dcache_mem
  import mem_bus_pkg::*;
  import dcache_pkg::*;
#(
  parameter int IDX_BITS = 5
) (
  input  logic                 clock,
  input  logic                 reset,
  input  logic [ADDR_BITS-1:0] lookup_addr,
  output logic                 hit,
  output logic [WORD_BITS-1:0] hit_data,
  input  logic                 store_en,
  input  logic [ADDR_BITS-1:0] store_addr,
  input  logic [WORD_BITS-1:0] store_data,
  input  logic                 fill_en,
  input  logic [ADDR_BITS-1:0] fill_addr,
  input  logic [WORD_BITS-1:0] fill_data
);

  localparam int LINES    = 1 << IDX_BITS;
  localparam int TAG_BITS = LINE_BITS - IDX_BITS;

  logic [WORD_BITS-1:0] data_mem [LINES];
  logic [TAG_BITS-1:0]  tag_mem  [LINES];
  logic [LINES-1:0]     valid;

  logic [IDX_BITS-1:0] lookup_idx;
  logic [TAG_BITS-1:0] lookup_tag;
  logic [IDX_BITS-1:0] store_idx;
  logic [TAG_BITS-1:0] store_tag;
  logic [IDX_BITS-1:0] fill_idx;
  logic [TAG_BITS-1:0] fill_tag;
  logic                store_hit;

  // address split: tag | index | byte offset
  assign lookup_idx = lookup_addr[OFFSET_BITS +: IDX_BITS];
  assign lookup_tag = lookup_addr[ADDR_BITS-1 -: TAG_BITS];
  assign store_idx  = store_addr[OFFSET_BITS +: IDX_BITS];
  assign store_tag  = store_addr[ADDR_BITS-1 -: TAG_BITS];
  assign fill_idx   = fill_addr[OFFSET_BITS +: IDX_BITS];
  assign fill_tag   = fill_addr[ADDR_BITS-1 -: TAG_BITS];

  assign hit      = valid[lookup_idx] && (tag_mem[lookup_idx] == lookup_tag);
  assign hit_data = data_mem[lookup_idx];

  // no write allocate, a store only touches a line it already owns
  assign store_hit = valid[store_idx] && (tag_mem[store_idx] == store_tag);

  always_ff @(posedge clock)
  begin
    if (reset)
      valid <= '0;
    else if (fill_en)
      valid[fill_idx] <= 1'b1;
  end

  always_ff @(posedge clock)
  begin
    if (store_en && store_hit)
      data_mem[store_idx] <= store_data;
    // fill assigned last, so it wins on a shared index
    if (fill_en)
    begin
      data_mem[fill_idx] <= fill_data;
      tag_mem[fill_idx]  <= fill_tag;
    end
  end

endmodule

`default_nettype wire

// ==== dcache_pkg.sv ====
// address split widths, register number widths and halt state encoding
`default_nettype none

package dcache_pkg;

  localparam int ADDR_BITS   = 32;                       // byte address
  localparam int OFFSET_BITS = 3;                        // byte in word, ignored
  localparam int LINE_BITS   = ADDR_BITS - OFFSET_BITS;  // tag plus index

  localparam int PR_BITS = 7;  // physical register number
  localparam int AR_BITS = 5;  // architectural register number

  // controller halt sequencing
  typedef enum logic [1:0] {
    run,
    draining,
    halted
  } halt_state_t;

endpackage

`default_nettype wire

// ==== dcache_props.sv ====
// concurrent assertions on the data-cache top level, attached by bind
`default_nettype none

module dcache_props
  import mem_bus_pkg::*;
(
  input logic     clock,
  input logic     reset,
  input logic     cdb_valid,
  input logic     halted,
  input logic     req_ready,
  input bus_cmd_t mem_command
);

  // outputs come out of reset quiet
  reset_quiet: assert property (@(posedge clock) $past(reset) |-> !cdb_valid && !halted)
    else $error("cdb_valid or halted high in the cycle after reset");

  halted_blocks: assert property (@(posedge clock) disable iff (reset) halted |-> !req_ready)
    else $error("req_ready high while halted");

  // bus stays idle once halted
  halted_idle: assert property (@(posedge clock) disable iff (reset)
    $past(halted) |-> mem_command == bus_none)
    else $error("bus command presented after halted");

endmodule

`default_nettype wire

// ==== dcache_tb.sv ====
// testbench for the data cache: clock, reset, memory model, stimulus tables and checks
`default_nettype none

module dcache_tb
  import mem_bus_pkg::*;
  import dcache_pkg::*;
();

  typedef struct packed {
    logic        st;
    logic [31:0] addr;
    logic [63:0] data;
  } op_t;

  // store to a line with a pending fill, a miss store, then reloads
  localparam op_t OPS [8] = '{
    '{1'b0, 32'h0000_0100, 64'h0},
    '{1'b1, 32'h0000_0100, 64'h1111_2222_3333_4444},
    '{1'b0, 32'h0000_0100, 64'h0},
    '{1'b1, 32'h0000_0200, 64'hdead_beef_0bad_f00d},
    '{1'b0, 32'h0000_0200, 64'h0},
    '{1'b0, 32'h0000_0208, 64'h0},
    '{1'b1, 32'h0000_0208, 64'h0123_4567_89ab_cdef},
    '{1'b0, 32'h0000_0208, 64'h0}
  };

  // all map to index 8, different tags
  localparam logic [31:0] CONFLICTS [6] = '{
    32'h0000_0040, 32'h0000_1040, 32'h0008_0040,
    32'h0000_1040, 32'h0000_0040, 32'hfff0_0040
  };

  logic clock, reset, req_valid, req_store, req_ready, halt, halted, cdb_valid;
  logic [ADDR_BITS-1:0]    req_addr, mem_addr;
  logic [WORD_BITS-1:0]    req_data, cdb_data, mem_data, mem_rdata;
  logic [PR_BITS-1:0]      req_pr, cdb_pr;
  logic [AR_BITS-1:0]      req_ar, cdb_ar;
  logic [BUS_TAG_BITS-1:0] mem_response, mem_tag;
  bus_cmd_t                mem_command;

  logic [31:0] seed = 32'd72;
  int          cycle = 0;
  logic        refuse = 1'b0;
  logic        taken;
  logic        want_valid = 1'b0, want_store = 1'b0, want_halt = 1'b0;
  logic [31:0] want_addr = '0;
  logic [63:0] want_data = '0;
  logic [6:0]  next_pr = '0, last_pr;

  logic [63:0] ref_mem [logic [28:0]];  // program order view
  logic [63:0] bus_mem [logic [28:0]];  // memory behind the bus
  logic        tag_busy [16];
  int          tag_due  [16];
  logic [63:0] tag_data [16];
  logic [31:0] st_addr_q [$];
  logic [63:0] st_data_q [$];

  logic        exp_pending [128];
  logic [4:0]  exp_ar      [128];
  logic [63:0] exp_data    [128];
  int          acc_cycle   [128];
  int          cdb_lat     [128];
  int stores_accepted = 0, stores_on_bus = 0, loads_accepted = 0, loads_on_bus = 0;
  int cdb_count = 0, outstanding = 0;

  dcache_top #(.IDX_BITS(5), .QUEUE_DEPTH(8)) dut (.*);

  bind dcache_top dcache_props props (
    .clock(clock), .reset(reset), .cdb_valid(cdb_valid), .halted(halted),
    .req_ready(req_ready), .mem_command(mem_command)
  );

  initial
  begin
    clock = 1'b0;
    forever #20 clock = ~clock;
  end

  function automatic logic [31:0] next_rand();
    seed = seed * 32'd1103515245 + 32'd12345;
    return {17'd0, seed[30:16]};
  endfunction

  // background pattern over the full word address
  function automatic logic [63:0] init_word(input logic [28:0] w);
    return {3'b101, w, 3'b010, ~w};
  endfunction

  function automatic logic [63:0] ref_read(input logic [28:0] w);
    return ref_mem.exists(w) ? ref_mem[w] : init_word(w);
  endfunction

  function automatic logic [63:0] bus_read(input logic [28:0] w);
    return bus_mem.exists(w) ? bus_mem[w] : init_word(w);
  endfunction

  task automatic compare(input logic [63:0] actual, input logic [63:0] expected,
                         input string msg);
    if (actual !== expected)
    begin
      $display("FAILED at time %0t: %s (got %h, expected %h)", $time, msg, actual, expected);
      $display("TEST FAILED");
      $fatal(1);
    end
  endtask

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  // one clock: drive at the falling edge, sample 10 units before the rising edge
  task automatic tick_cycle();
    int t;
    int start;
    int ret;
    @(negedge clock);
    cycle++;
    req_valid = want_valid;
    req_store = want_store;
    req_addr  = want_addr;
    req_data  = want_data;
    req_pr    = last_pr;
    req_ar    = last_pr[4:0] ^ 5'h15;
    halt      = want_halt;
    mem_tag   = '0;
    mem_rdata = '0;
    ret       = 0;
    for (t = 1; t < 16; t++)
      if (ret == 0 && tag_busy[t] && tag_due[t] <= cycle)
        ret = t;
    if (ret != 0)
    begin
      mem_tag       = BUS_TAG_BITS'(ret);
      mem_rdata     = tag_data[ret];
      tag_busy[ret] = 1'b0;
    end
    mem_response = '0;
    if (mem_command != bus_none && !refuse && next_rand() % 4 != 0)
    begin
      start = int'(next_rand() % 15);
      for (int i = 0; i < 15; i++)
      begin
        t = 1 + (start + i) % 15;
        if (mem_response == '0 && !tag_busy[t] && t != ret)
          mem_response = BUS_TAG_BITS'(t);
      end
      t = int'(mem_response);
      if (t != 0 && mem_command == bus_load)
      begin
        tag_busy[t] = 1'b1;
        tag_due[t]  = cycle + 2 + int'(next_rand() % 9);
        tag_data[t] = bus_read(mem_addr[31:3]);
        loads_on_bus++;
      end
      else if (t != 0)
      begin
        compare(st_addr_q.size() != 0, 1'b1, "bus store with no store accepted");
        compare(mem_addr, st_addr_q.pop_front(), "bus store address out of order");
        compare(mem_data, st_data_q.pop_front(), "bus store data out of order");
        bus_mem[mem_addr[31:3]] = mem_data;
        stores_on_bus++;
      end
    end
    #10;
    if (halted)
      compare(mem_command, bus_none, "bus command after halted");
    taken = req_valid && req_ready;
    if (taken && req_store)
    begin
      ref_mem[req_addr[31:3]] = req_data;
      st_addr_q.push_back(req_addr);
      st_data_q.push_back(req_data);
      stores_accepted++;
    end
    else if (taken)
    begin
      exp_pending[req_pr] = 1'b1;
      exp_ar[req_pr]      = req_ar;
      exp_data[req_pr]    = ref_read(req_addr[31:3]);
      acc_cycle[req_pr]   = cycle;
      loads_accepted++;
      outstanding++;
    end
    if (cdb_valid)
    begin
      compare(exp_pending[cdb_pr], 1'b1, "CDB broadcast for a pr with no load outstanding");
      compare(cdb_ar, exp_ar[cdb_pr], "CDB architectural register");
      compare(cdb_data, exp_data[cdb_pr], "CDB load data");
      exp_pending[cdb_pr] = 1'b0;
      cdb_lat[cdb_pr]     = cycle - acc_cycle[cdb_pr];
      outstanding--;
      cdb_count++;
    end
  endtask

  task automatic prepare_request(input logic st, input logic [31:0] addr,
                                 input logic [63:0] data);
    want_valid = 1'b1;
    want_store = st;
    want_addr  = addr;
    want_data  = data;
    last_pr    = next_pr;
    next_pr    = next_pr + 7'd1;
  endtask

  task automatic flush_queue();
    int waited;
    waited     = 0;
    want_valid = 1'b0;
    do
    begin
      tick_cycle();
      waited++;
      if (waited > 300)
        abort_run("miss queue never emptied before a store");
    end
    while (mem_command != bus_none);
  endtask

  // stores wait for earlier loads to reach the bus
  task automatic issue_request(input logic st, input logic [31:0] addr,
                               input logic [63:0] data);
    int waited;
    waited = 0;
    if (st)
      flush_queue();
    prepare_request(st, addr, data);
    do
    begin
      tick_cycle();
      waited++;
      if (waited > 200)
        abort_run("request was never accepted by the cache");
    end
    while (!taken);
    want_valid = 1'b0;
  endtask

  task automatic wait_drain();
    int waited;
    logic busy;
    waited = 0;
    do
    begin
      tick_cycle();
      busy = 1'b0;
      for (int t = 1; t < 16; t++)
        busy = busy | tag_busy[t];
      waited++;
      if (waited > 500)
        abort_run("outstanding loads never completed");
    end
    while (outstanding != 0 || busy || mem_command != bus_none);
  endtask

  initial
  begin
    int   waited;
    logic seen_full;
    logic [31:0] r;
    for (int t = 0; t < 16; t++)
      tag_busy[t] = 1'b0;
    for (int p = 0; p < 128; p++)
      exp_pending[p] = 1'b0;
    last_pr = '0;
    reset = 1'b1;
    req_valid = 1'b0;
    req_store = 1'b0;
    req_addr = '0;
    req_data = '0;
    req_pr = '0;
    req_ar = '0;
    halt = 1'b0;
    mem_response = '0;
    mem_tag = '0;
    mem_rdata = '0;
    repeat (5) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;

    foreach (OPS[i])
      issue_request(OPS[i].st, OPS[i].addr, OPS[i].data);
    foreach (CONFLICTS[i])
      issue_request(1'b0, CONFLICTS[i], 64'h0);
    wait_drain();

    // a completed fill makes the next load a one-cycle hit
    for (int i = 0; i < 3; i++)
    begin
      issue_request(1'b0, CONFLICTS[i], 64'h0);
      wait_drain();
      issue_request(1'b0, CONFLICTS[i], 64'h0);
      wait_drain();
      compare(cdb_lat[last_pr], 1, "load hit latency");
    end

    for (int i = 0; i < 80; i++)
    begin
      r = next_rand();
      if (r % 4 == 0)
        issue_request(1'b1, 32'h2000 + ((r % 3) << 8) + ((r >> 4) % 32) * 8,
                      {next_rand(), next_rand()});
      else
        issue_request(1'b0, 32'h2000 + ((r % 3) << 8) + ((r >> 4) % 32) * 8, 64'h0);
    end
    wait_drain();

    // memory refuses everything until the queue backs up
    refuse = 1'b1;
    seen_full = 1'b0;
    waited = 0;
    prepare_request(1'b0, 32'h0004_0000, 64'h0);
    while (!seen_full)
    begin
      tick_cycle();
      if (taken)
        prepare_request(1'b0, 32'h0004_0000 + 32'(next_pr) * 8, 64'h0);
      else if (!req_ready && mem_tag == '0)
        seen_full = 1'b1;
      waited++;
      if (waited > 100)
        abort_run("req_ready never dropped while memory refused commands");
    end
    want_valid = 1'b0;
    refuse = 1'b0;
    wait_drain();

    for (int i = 0; i < 5; i++)
      issue_request(1'b0, 32'h0009_0000 + i * 8, 64'h0);
    want_halt = 1'b1;
    tick_cycle();
    want_halt = 1'b0;
    prepare_request(1'b0, 32'h0000_0100, 64'h0);
    waited = 0;
    do
    begin
      tick_cycle();
      compare(req_ready, 1'b0, "req_ready after halt");
      waited++;
      if (waited > 500)
        abort_run("halted never rose after halt");
    end
    while (!halted);
    compare(outstanding, 0, "loads outstanding when halted rose");
    repeat (10)
    begin
      tick_cycle();
      compare(taken, 1'b0, "request accepted while halted");
    end

    compare(stores_on_bus, stores_accepted, "bus stores against accepted stores");
    compare(loads_on_bus <= loads_accepted, 1'b1, "more bus loads than accepted loads");
    compare(cdb_count, loads_accepted, "CDB broadcasts against accepted loads");
    compare(st_addr_q.size(), 0, "stores never reached the bus");
    $display("TEST PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== dcache_top.sv ====
// data-cache top level wiring controller, cache arrays, miss queue and fill tracker
`default_nettype none

module dcache_top
  import mem_bus_pkg::*;
  import dcache_pkg::*;
#(
  parameter int IDX_BITS    = 5,
  parameter int QUEUE_DEPTH = 8
) (
  input  logic                    clock,
  input  logic                    reset,
  input  logic                    req_valid,
  input  logic                    req_store,
  input  logic [ADDR_BITS-1:0]    req_addr,
  input  logic [WORD_BITS-1:0]    req_data,
  input  logic [PR_BITS-1:0]      req_pr,
  input  logic [AR_BITS-1:0]      req_ar,
  output logic                    req_ready,
  input  logic                    halt,
  output logic                    halted,
  output logic                    cdb_valid,
  output logic [PR_BITS-1:0]      cdb_pr,
  output logic [AR_BITS-1:0]      cdb_ar,
  output logic [WORD_BITS-1:0]    cdb_data,
  output bus_cmd_t                mem_command,
  output logic [ADDR_BITS-1:0]    mem_addr,
  output logic [WORD_BITS-1:0]    mem_data,
  input  logic [BUS_TAG_BITS-1:0] mem_response,
  input  logic [BUS_TAG_BITS-1:0] mem_tag,
  input  logic [WORD_BITS-1:0]    mem_rdata
);

  logic                    hit;
  logic [WORD_BITS-1:0]    hit_data;
  logic                    queue_full;
  logic                    queue_empty;
  logic                    push;
  bus_cmd_t                push_cmd;
  logic [ADDR_BITS-1:0]    push_addr;
  logic [WORD_BITS-1:0]    push_data;
  logic [PR_BITS-1:0]      push_pr;
  logic [AR_BITS-1:0]      push_ar;
  logic                    record;
  logic [BUS_TAG_BITS-1:0] record_num;
  logic [PR_BITS-1:0]      record_pr;
  logic [AR_BITS-1:0]      record_ar;
  logic [ADDR_BITS-1:0]    record_addr;
  logic                    fill_valid;
  logic [PR_BITS-1:0]      fill_pr;
  logic [AR_BITS-1:0]      fill_ar;
  logic [ADDR_BITS-1:0]    fill_addr;
  logic [WORD_BITS-1:0]    fill_data;
  logic                    fill_alloc;
  logic                    any_pending;
  logic                    store_en;
  logic                    store_strobe;
  logic [ADDR_BITS-1:0]    store_addr;
  logic [WORD_BITS-1:0]    store_data;
  logic                    fill_en;
  logic [ADDR_BITS-1:0]    fill_wr_addr;
  logic [WORD_BITS-1:0]    fill_wr_data;

  dcache_ctrl #(
    .IDX_BITS(IDX_BITS)
  ) ctrl (
    .clock(clock), .reset(reset),
    .req_valid(req_valid), .req_store(req_store), .req_addr(req_addr),
    .req_data(req_data), .req_pr(req_pr), .req_ar(req_ar), .req_ready(req_ready),
    .halt(halt), .halted(halted),
    .hit(hit), .hit_data(hit_data),
    .queue_full(queue_full), .queue_empty(queue_empty),
    .push(push), .push_cmd(push_cmd), .push_addr(push_addr),
    .push_data(push_data), .push_pr(push_pr), .push_ar(push_ar),
    .fill_valid(fill_valid), .fill_pr(fill_pr), .fill_ar(fill_ar),
    .fill_addr(fill_addr), .fill_data(fill_data), .fill_alloc(fill_alloc),
    .any_pending(any_pending),
    .store_en(store_en), .store_strobe(store_strobe),
    .store_addr(store_addr), .store_data(store_data),
    .fill_en(fill_en), .fill_wr_addr(fill_wr_addr), .fill_wr_data(fill_wr_data),
    .cdb_valid(cdb_valid), .cdb_pr(cdb_pr), .cdb_ar(cdb_ar), .cdb_data(cdb_data)
  );

  // lookup runs straight off the incoming request
  dcache_mem #(
    .IDX_BITS(IDX_BITS)
  ) mem (
    .clock(clock), .reset(reset),
    .lookup_addr(req_addr), .hit(hit), .hit_data(hit_data),
    .store_en(store_en), .store_addr(store_addr), .store_data(store_data),
    .fill_en(fill_en), .fill_addr(fill_wr_addr), .fill_data(fill_wr_data)
  );

  miss_queue #(
    .QUEUE_DEPTH(QUEUE_DEPTH)
  ) queue (
    .clock(clock), .reset(reset),
    .push(push), .push_cmd(push_cmd), .push_addr(push_addr),
    .push_data(push_data), .push_pr(push_pr), .push_ar(push_ar),
    .full(queue_full), .empty(queue_empty),
    .mem_command(mem_command), .mem_addr(mem_addr), .mem_data(mem_data),
    .mem_response(mem_response),
    .record(record), .record_num(record_num), .record_pr(record_pr),
    .record_ar(record_ar), .record_addr(record_addr)
  );

  fill_tracker #(
    .IDX_BITS(IDX_BITS)
  ) tracker (
    .clock(clock), .reset(reset),
    .record(record), .record_num(record_num), .record_pr(record_pr),
    .record_ar(record_ar), .record_addr(record_addr),
    .store_strobe(store_strobe), .store_addr(store_addr),
    .mem_tag(mem_tag), .mem_rdata(mem_rdata),
    .fill_valid(fill_valid), .fill_pr(fill_pr), .fill_ar(fill_ar),
    .fill_addr(fill_addr), .fill_data(fill_data), .fill_alloc(fill_alloc),
    .any_pending(any_pending)
  );

endmodule

`default_nettype wire

// ==== fill_tracker.sv ====
// table of outstanding loads indexed by bus tag, matched against returning data
`default_nettype none

module fill_tracker
  import mem_bus_pkg::*;
  import dcache_pkg::*;
#(
  parameter int IDX_BITS = 5
) (
  input  logic                    clock,
  input  logic                    reset,
  input  logic                    record,
  input  logic [BUS_TAG_BITS-1:0] record_num,
  input  logic [PR_BITS-1:0]      record_pr,
  input  logic [AR_BITS-1:0]      record_ar,
  input  logic [ADDR_BITS-1:0]    record_addr,
  input  logic                    store_strobe,
  input  logic [ADDR_BITS-1:0]    store_addr,
  input  logic [BUS_TAG_BITS-1:0] mem_tag,
  input  logic [WORD_BITS-1:0]    mem_rdata,
  output logic                    fill_valid,
  output logic [PR_BITS-1:0]      fill_pr,
  output logic [AR_BITS-1:0]      fill_ar,
  output logic [ADDR_BITS-1:0]    fill_addr,
  output logic [WORD_BITS-1:0]    fill_data,
  output logic                    fill_alloc,
  output logic                    any_pending
);

  localparam int TAG_BITS = LINE_BITS - IDX_BITS;

  logic [NUM_BUS_TAGS-1:0] occupied;
  logic [NUM_BUS_TAGS-1:0] alloc;  // fill may still write the cache
  logic [PR_BITS-1:0]      ent_pr  [NUM_BUS_TAGS];
  logic [AR_BITS-1:0]      ent_ar  [NUM_BUS_TAGS];
  logic [IDX_BITS-1:0]     ent_idx [NUM_BUS_TAGS];
  logic [TAG_BITS-1:0]     ent_tag [NUM_BUS_TAGS];

  logic [IDX_BITS-1:0]     record_idx;
  logic [TAG_BITS-1:0]     record_tag;
  logic [IDX_BITS-1:0]     store_idx;
  logic [TAG_BITS-1:0]     store_tag;
  logic [NUM_BUS_TAGS-1:0] store_match;
  logic                    record_match;

  assign record_idx = record_addr[OFFSET_BITS +: IDX_BITS];
  assign record_tag = record_addr[ADDR_BITS-1 -: TAG_BITS];
  assign store_idx  = store_addr[OFFSET_BITS +: IDX_BITS];
  assign store_tag  = store_addr[ADDR_BITS-1 -: TAG_BITS];

  // entries whose line a newer store just overwrote
  always_comb
  begin
    for (int i = 0; i < NUM_BUS_TAGS; i++)
      store_match[i] = store_strobe && occupied[i] &&
                       (ent_idx[i] == store_idx) && (ent_tag[i] == store_tag);
  end

  // store landing in the same cycle as the record
  assign record_match = store_strobe && (record_idx == store_idx) &&
                        (record_tag == store_tag);

  assign fill_valid  = (mem_tag != '0) && occupied[mem_tag];
  assign fill_pr     = ent_pr[mem_tag];
  assign fill_ar     = ent_ar[mem_tag];
  assign fill_addr   = {ent_tag[mem_tag], ent_idx[mem_tag], {OFFSET_BITS{1'b0}}};
  assign fill_data   = mem_rdata;
  assign fill_alloc  = alloc[mem_tag];
  assign any_pending = |occupied;

  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      occupied <= '0;
      alloc    <= '0;
    end
    else
    begin
      alloc <= alloc & ~store_match;
      if (fill_valid)
        occupied[mem_tag] <= 1'b0;  // entry freed as data returns
      if (record)
      begin
        occupied[record_num] <= 1'b1;
        alloc[record_num]    <= !record_match;
      end
    end
  end

  always_ff @(posedge clock)
  begin
    if (record)
    begin
      ent_pr[record_num]  <= record_pr;
      ent_ar[record_num]  <= record_ar;
      ent_idx[record_num] <= record_idx;
      ent_tag[record_num] <= record_tag;
    end
  end

endmodule

`default_nettype wire

// ==== list.f ====
mem_bus_pkg.sv
dcache_pkg.sv
dcache_mem.sv
miss_queue.sv
fill_tracker.sv
dcache_ctrl.sv
dcache_top.sv
dcache_props.sv
dcache_tb.sv

// ==== mem_bus_pkg.sv ====
// memory bus command encoding, bus tag sizing and data width
`default_nettype none

package mem_bus_pkg;

  // command presented to memory, bus_none when idle
  typedef enum logic [1:0] {
    bus_none  = 2'd0,
    bus_load  = 2'd1,
    bus_store = 2'd2
  } bus_cmd_t;

  // response and tag numbers, zero is reserved for nothing
  localparam int BUS_TAG_BITS = 4;
  localparam int NUM_BUS_TAGS = 16;

  localparam int WORD_BITS = 64;  // one word per transfer

endpackage

`default_nettype wire

// ==== miss_queue.sv ====
// FIFO of pending bus commands presenting its head to the memory bus
`default_nettype none

module miss_queue
  import mem_bus_pkg::*;
  import dcache_pkg::*;
#(
  parameter int QUEUE_DEPTH = 8
) (
  input  logic                    clock,
  input  logic                    reset,
  input  logic                    push,
  input  bus_cmd_t                push_cmd,
  input  logic [ADDR_BITS-1:0]    push_addr,
  input  logic [WORD_BITS-1:0]    push_data,
  input  logic [PR_BITS-1:0]      push_pr,
  input  logic [AR_BITS-1:0]      push_ar,
  output logic                    full,
  output logic                    empty,
  output bus_cmd_t                mem_command,
  output logic [ADDR_BITS-1:0]    mem_addr,
  output logic [WORD_BITS-1:0]    mem_data,
  input  logic [BUS_TAG_BITS-1:0] mem_response,
  output logic                    record,
  output logic [BUS_TAG_BITS-1:0] record_num,
  output logic [PR_BITS-1:0]      record_pr,
  output logic [AR_BITS-1:0]      record_ar,
  output logic [ADDR_BITS-1:0]    record_addr
);

  localparam int PTR_BITS = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
  localparam int CNT_BITS = $clog2(QUEUE_DEPTH + 1);

  bus_cmd_t             cmd_q  [QUEUE_DEPTH];
  logic [ADDR_BITS-1:0] addr_q [QUEUE_DEPTH];
  logic [WORD_BITS-1:0] data_q [QUEUE_DEPTH];
  logic [PR_BITS-1:0]   pr_q   [QUEUE_DEPTH];
  logic [AR_BITS-1:0]   ar_q   [QUEUE_DEPTH];

  logic [PTR_BITS-1:0] head;
  logic [PTR_BITS-1:0] tail;
  logic [CNT_BITS-1:0] count;
  logic                pop;

  // wrap for depths that are not a power of two
  function automatic logic [PTR_BITS-1:0] bump(input logic [PTR_BITS-1:0] ptr);
    return (ptr == PTR_BITS'(QUEUE_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign full  = (count == CNT_BITS'(QUEUE_DEPTH));
  assign empty = (count == '0);

  assign mem_command = empty ? bus_none : cmd_q[head];
  assign mem_addr    = addr_q[head];
  assign mem_data    = data_q[head];

  // zero response means refused, head stays put
  assign pop = !empty && (mem_response != '0);

  // only loads wait for data
  assign record      = pop && (cmd_q[head] == bus_load);
  assign record_num  = mem_response;
  assign record_pr   = pr_q[head];
  assign record_ar   = ar_q[head];
  assign record_addr = addr_q[head];

  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end
    else
    begin
      if (push)
        tail <= bump(tail);
      if (pop)
        head <= bump(head);
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // idle, or push and pop together
      endcase
    end
  end

  always_ff @(posedge clock)
  begin
    if (push)
    begin
      cmd_q[tail]  <= push_cmd;
      addr_q[tail] <= push_addr;
      data_q[tail] <= push_data;
      pr_q[tail]   <= push_pr;
      ar_q[tail]   <= push_ar;
    end
  end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# build and run the data-cache testbench with Verilator
verilator --binary --timing --assert -f list.f --top-module dcache_tb -o sim_dcache \
  && ./obj_dir/sim_dcache | grep "TEST PASSED" \
  || { echo "simulation failed"; exit 1; }
